/* common/line_pkg.sv */
// line package: sizes and the line/beat view shared by the adaptor, the memory and the top

package line_pkg;

    // ========================================
    // line and beat geometry
    // ========================================
    localparam int LINE_BITS      = 256;
    localparam int BEAT_BITS      = 64;
    localparam int BEATS_PER_LINE = LINE_BITS / BEAT_BITS;
    localparam int BEAT_IDX_BITS  = $clog2(BEATS_PER_LINE);

    // index of the final beat of a burst
    localparam logic [BEAT_IDX_BITS-1:0] LAST_BEAT = BEAT_IDX_BITS'(BEATS_PER_LINE - 1);

    // ========================================
    // addressing
    // ========================================
    localparam int ADDR_BITS        = 32;
    localparam int LINE_OFFSET_BITS = 5;    // byte within a line, ignored by the memory
    localparam int MEM_INDEX_BITS   = 6;
    localparam int MEM_LINES        = 1 << MEM_INDEX_BITS;

    // ========================================
    // memory timing
    // ========================================
    // cycles between accepting a request and the first beat, at least 1
    localparam int MEM_LATENCY  = 3;
    localparam int LAT_CNT_BITS = $clog2(MEM_LATENCY + 1);

    // one cache line, either as a flat word or as four beats
    // beat 0 sits in bits 63:0
    typedef union packed
    {
        logic [LINE_BITS-1:0]                      flat;
        logic [BEATS_PER_LINE-1:0][BEAT_BITS-1:0]  beat;
    } line_t;

endpackage : line_pkg

/* cacheline_adaptor/cacheline_adaptor.sv */
// cacheline adaptor: splits 256-bit lines into 64-bit memory beats and gathers beats into lines
`timescale 1ns/100ps

module cacheline_adaptor
(
    input  logic                              clk,
    input  logic                              reset_n,

    // last-level cache side
    input  line_pkg::line_t                   line_i,
    output line_pkg::line_t                   line_o,
    input  logic [line_pkg::ADDR_BITS-1:0]    address_i,
    input  logic                              read_i,
    input  logic                              write_i,
    output logic                              resp_o,

    // burst memory side
    input  logic [line_pkg::BEAT_BITS-1:0]    burst_i,
    output logic [line_pkg::BEAT_BITS-1:0]    burst_o,
    output logic [line_pkg::ADDR_BITS-1:0]    address_o,
    output logic                              read_o,
    output logic                              write_o,
    input  logic                              resp_i
);

    import line_pkg::*;

    typedef enum logic [3:0]
    {
        IDLE,
        READ_1,
        READ_2,
        READ_3,
        READ_4,
        READ,
        WRITE_1,
        WRITE_2,
        WRITE_3,
        WRITE_4
    } state_t;

    state_t                   state;
    state_t                   next_state;
    logic [BEAT_IDX_BITS-1:0] beat_sel;    // beat handled by the current state
    logic                     reading;     // READ_1..READ_4
    logic                     writing;     // WRITE_1..WRITE_4

    // ========================================
    // state decode
    // ========================================
    always_comb
    begin : beat_decode
        beat_sel = '0;
        reading  = 1'b0;
        writing  = 1'b0;
        case (state)
            READ_1:
            begin
                beat_sel = 2'd0;
                reading  = 1'b1;
            end
            READ_2:
            begin
                beat_sel = 2'd1;
                reading  = 1'b1;
            end
            READ_3:
            begin
                beat_sel = 2'd2;
                reading  = 1'b1;
            end
            READ_4:
            begin
                beat_sel = 2'd3;
                reading  = 1'b1;
            end
            WRITE_1:
            begin
                beat_sel = 2'd0;
                writing  = 1'b1;
            end
            WRITE_2:
            begin
                beat_sel = 2'd1;
                writing  = 1'b1;
            end
            WRITE_3:
            begin
                beat_sel = 2'd2;
                writing  = 1'b1;
            end
            WRITE_4:
            begin
                beat_sel = 2'd3;
                writing  = 1'b1;
            end
            default:
            begin
                beat_sel = '0;
            end
        endcase
    end

    // ========================================
    // next state and memory strobes
    // ========================================
    always_comb
    begin : next_state_logic
        next_state = state;
        read_o     = 1'b0;
        write_o    = 1'b0;
        case (state)
            IDLE:
            begin
                if (read_i)
                begin
                    read_o     = 1'b1;
                    next_state = READ_1;
                end
                else if (write_i)
                begin
                    write_o    = 1'b1;
                    next_state = WRITE_1;
                end
            end
            READ_1:
            begin
                read_o = 1'b1;
                if (resp_i)
                    next_state = READ_2;
            end
            // remaining beats arrive back to back
            READ_2:
            begin
                read_o     = 1'b1;
                next_state = READ_3;
            end
            READ_3:
            begin
                read_o     = 1'b1;
                next_state = READ_4;
            end
            READ_4:
            begin
                read_o     = 1'b1;
                next_state = READ;
            end
            READ:
            begin
                next_state = IDLE;
            end
            WRITE_1:
            begin
                write_o = 1'b1;
                if (resp_i)
                    next_state = WRITE_2;
            end
            WRITE_2:
            begin
                write_o = 1'b1;
                if (resp_i)
                    next_state = WRITE_3;
            end
            WRITE_3:
            begin
                write_o = 1'b1;
                if (resp_i)
                    next_state = WRITE_4;
            end
            WRITE_4:
            begin
                write_o = !resp_i;    // drop with the last beat
                if (resp_i)
                    next_state = IDLE;
            end
            default:
            begin
                next_state = IDLE;
            end
        endcase
    end

    assign address_o = address_i;
    assign burst_o   = writing ? line_i.beat[beat_sel] : '0;
    assign resp_o    = (state == READ) || (state == WRITE_4 && resp_i);

    always_ff @(posedge clk)
    begin : state_register
        if (!reset_n)
            state <= IDLE;
        else
            state <= next_state;
    end

    // line is assembled in place, then cleared once READ is left
    always_ff @(posedge clk)
    begin : line_assembly
        if (!reset_n)
            line_o <= '0;
        else if (reading)
        begin
            if (state != READ_1 || resp_i)
                line_o.beat[beat_sel] <= burst_i;
        end
        else
            line_o <= '0;
    end

    // ========================================
    // assertions
    // ========================================
    a_one_direction : assert property (@(posedge clk) disable iff (!reset_n)
        !(read_o && write_o))
        else $error("adaptor drives read_o and write_o together");

    a_resp_pulse : assert property (@(posedge clk) disable iff (!reset_n)
        resp_o |=> !resp_o)
        else $error("adaptor resp_o held longer than one cycle");

endmodule : cacheline_adaptor

/* burst_memory/burst_memory.sv */
// burst memory: line store that answers each request with four beats after a fixed latency
`timescale 1ns/100ps

module burst_memory
(
    input  logic                              clk,
    input  logic                              reset_n,

    input  logic [line_pkg::ADDR_BITS-1:0]    address_i,
    input  logic                              read_i,
    input  logic                              write_i,
    input  logic [line_pkg::BEAT_BITS-1:0]    burst_i,
    output logic [line_pkg::BEAT_BITS-1:0]    burst_o,
    output logic                              resp_o
);

    import line_pkg::*;

    typedef enum logic [1:0]
    {
        MEM_IDLE,
        MEM_WAIT,
        MEM_STREAM
    } phase_t;

    phase_t                    phase;
    logic [LAT_CNT_BITS-1:0]   lat_cnt;
    logic [BEAT_IDX_BITS-1:0]  beat_cnt;
    logic [MEM_INDEX_BITS-1:0] index_q;     // line selected at acceptance
    logic                      dir_write;   // latched direction, 1 for write
    logic                      accept;

    line_t                     mem [MEM_LINES];

    // ========================================
    // request control
    // ========================================
    assign accept = (phase == MEM_IDLE) && (read_i || write_i);

    always_ff @(posedge clk)
    begin : phase_control
        if (!reset_n)
        begin
            phase    <= MEM_IDLE;
            lat_cnt  <= '0;
            beat_cnt <= '0;
        end
        else
        begin
            case (phase)
                MEM_IDLE:
                begin
                    if (accept)
                    begin
                        phase   <= MEM_WAIT;
                        lat_cnt <= LAT_CNT_BITS'(MEM_LATENCY - 1);
                    end
                end
                MEM_WAIT:
                begin
                    if (lat_cnt == '0)
                    begin
                        phase    <= MEM_STREAM;
                        beat_cnt <= '0;
                    end
                    else
                        lat_cnt <= lat_cnt - 1'b1;
                end
                MEM_STREAM:
                begin
                    beat_cnt <= beat_cnt + 1'b1;
                    if (beat_cnt == LAST_BEAT)
                        phase <= MEM_IDLE;
                end
                default:
                begin
                    phase <= MEM_IDLE;
                end
            endcase
        end
    end

    // index and direction only change on acceptance
    always_ff @(posedge clk)
    begin : request_latch
        if (accept)
        begin
            index_q   <= address_i[LINE_OFFSET_BITS +: MEM_INDEX_BITS];
            dir_write <= write_i && !read_i;
        end
    end

    // ========================================
    // storage
    // ========================================
    always_ff @(posedge clk)
    begin : beat_store
        if (phase == MEM_STREAM && dir_write)
            mem[index_q].beat[beat_cnt] <= burst_i;
    end

    assign resp_o  = (phase == MEM_STREAM);
    assign burst_o = (resp_o && !dir_write) ? mem[index_q].beat[beat_cnt] : '0;

    // ========================================
    // assertions
    // ========================================
    a_resp_length : assert property (@(posedge clk) disable iff (!reset_n)
        (resp_o && $past(resp_o) && $past(resp_o, 2) && $past(resp_o, 3)) |=> !resp_o)
        else $error("memory resp_o high for more than four cycles");

    // requester must keep the write strobe up until the final beat
    a_write_held : assert property (@(posedge clk) disable iff (!reset_n)
        (resp_o && dir_write && beat_cnt != LAST_BEAT) |-> write_i)
        else $error("write_i dropped before the last beat of a write burst");

endmodule : burst_memory

/* rtl/line_memory_top.sv */
// line memory top: cacheline adaptor joined to the burst memory, cache port only
`timescale 1ns/100ps

module line_memory_top
(
    input  logic                              clk,
    input  logic                              reset_n,

    input  line_pkg::line_t                   line_i,
    input  logic [line_pkg::ADDR_BITS-1:0]    address_i,
    input  logic                              read_i,
    input  logic                              write_i,
    output line_pkg::line_t                   line_o,
    output logic                              resp_o
);

    import line_pkg::*;

    // adaptor to memory
    logic [BEAT_BITS-1:0] wr_burst;
    logic [ADDR_BITS-1:0] mem_address;
    logic                 mem_read;
    logic                 mem_write;

    // memory to adaptor
    logic [BEAT_BITS-1:0] rd_burst;
    logic                 mem_resp;

    cacheline_adaptor u_adaptor
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .line_i    (line_i),
        .line_o    (line_o),
        .address_i (address_i),
        .read_i    (read_i),
        .write_i   (write_i),
        .resp_o    (resp_o),
        .burst_i   (rd_burst),
        .burst_o   (wr_burst),
        .address_o (mem_address),
        .read_o    (mem_read),
        .write_o   (mem_write),
        .resp_i    (mem_resp)
    );

    burst_memory u_memory
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .address_i (mem_address),
        .read_i    (mem_read),
        .write_i   (mem_write),
        .burst_i   (wr_burst),
        .burst_o   (rd_burst),
        .resp_o    (mem_resp)
    );

endmodule : line_memory_top

/* bench/tb_tasks.svh */
// directed line memory tests with the transfer and compare helpers they share

// ========================================
// helpers
// ========================================
task automatic note_error(input string msg);
    $display("error: %s at %0t", msg, $time);
    error_count = error_count + 1;
endtask

task automatic compare_value(input string name, input logic [LINE_BITS-1:0] expected,
                             input logic [LINE_BITS-1:0] actual);
    if (actual !== expected)
    begin
        $display("Fail %s: expected %0h, got %0h", name, expected, actual);
        error_count = error_count + 1;
    end
endtask

task automatic finish_test(input string name, input int errors_before);
    if (error_count == errors_before)
    begin
        $display("%s: passed", name);
        tests_passed = tests_passed + 1;
    end
    else
    begin
        $display("%s: FAILED with %0d errors", name, error_count - errors_before);
        tests_failed = tests_failed + 1;
    end
endtask

task automatic random_line(output line_t data);
    for (int i = 0; i < LINE_BITS / 32; i++)
        data.flat[i*32 +: 32] = $random(seed);
endtask

function automatic int line_index(input logic [ADDR_BITS-1:0] addr);
    return int'(addr[LINE_OFFSET_BITS +: MEM_INDEX_BITS]);
endfunction

function automatic logic [ADDR_BITS-1:0] line_address(input int index, input int offset);
    return (ADDR_BITS'(index) << LINE_OFFSET_BITS) | ADDR_BITS'(offset);
endfunction

// counts falling edges until resp_o is seen
task automatic wait_resp(output int cycles);
    logic seen;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < XFER_CYCLES * 2)
    begin
        @(negedge clk);
        cycles = cycles + 1;
        seen   = resp_o;
    end
    if (!seen)
        note_error("resp_o never rose for the pending request");
endtask

task automatic write_line(input logic [ADDR_BITS-1:0] addr, input line_t data,
                          output int cycles);
    @(negedge clk);
    address_i = addr;
    line_i    = data;
    write_i   = 1'b1;
    wait_resp(cycles);
    write_i = 1'b0;    // dropped in the resp_o cycle
    shadow[line_index(addr)] = data;
    @(negedge clk);
    compare_value("resp_o after write", '0, {255'b0, resp_o});
endtask

task automatic read_line(input logic [ADDR_BITS-1:0] addr, output line_t data,
                         output int cycles);
    @(negedge clk);
    address_i = addr;
    read_i    = 1'b1;
    wait_resp(cycles);
    data   = line_o;
    read_i = 1'b0;
    @(negedge clk);
    compare_value("resp_o after read", '0, {255'b0, resp_o});
    compare_value("line_o after read", '0, line_o.flat);
endtask

// ========================================
// tests
// ========================================
task automatic verify_reset();
    int errors_before;
    errors_before = error_count;
    reset_n = 1'b0;
    repeat (RESET_CYCLES)
    begin
        @(negedge clk);
        compare_value("resp_o in reset", '0, {255'b0, resp_o});
        compare_value("line_o in reset", '0, line_o.flat);
    end
    reset_n = 1'b1;
    repeat (2)
    begin
        @(negedge clk);
        compare_value("resp_o after reset", '0, {255'b0, resp_o});
        compare_value("line_o after reset", '0, line_o.flat);
    end
    finish_test("reset state", errors_before);
endtask

task automatic readback_line();
    int    errors_before;
    int    cycles;
    line_t data;
    line_t got;
    errors_before = error_count;
    random_line(data);
    write_line(line_address(5, 0), data, cycles);
    read_line(line_address(5, 0), got, cycles);
    for (int b = 0; b < BEATS_PER_LINE; b++)
        compare_value($sformatf("line_o beat %0d", b), LINE_BITS'(data.beat[b]),
                      LINE_BITS'(got.beat[b]));
    finish_test("write then read", errors_before);
endtask

task automatic measure_latency();
    int    errors_before;
    int    cycles;
    line_t data;
    line_t got;
    errors_before = error_count;
    random_line(data);
    write_line(line_address(12, 0), data, cycles);
    compare_value("write resp_o cycle", LINE_BITS'(WRITE_RESP_CYCLE), LINE_BITS'(cycles));
    read_line(line_address(12, 0), got, cycles);
    compare_value("read resp_o cycle", LINE_BITS'(READ_RESP_CYCLE), LINE_BITS'(cycles));
    compare_value("line_o", data.flat, got.flat);
    finish_test("fixed latency", errors_before);
endtask

task automatic scatter_lines();
    int    errors_before;
    int    cycles;
    line_t data;
    line_t got;
    int    write_order [6] = '{3, 17, 42, 8, 63, 0};
    int    read_order [6]  = '{42, 0, 17, 63, 3, 8};
    errors_before = error_count;
    foreach (write_order[i])
    begin
        random_line(data);
        write_line(line_address(write_order[i], 0), data, cycles);
    end
    foreach (read_order[i])
    begin
        read_line(line_address(read_order[i], 0), got, cycles);
        compare_value($sformatf("line_o index %0d", read_order[i]),
                      shadow[read_order[i]].flat, got.flat);
    end
    finish_test("independent lines", errors_before);
endtask

task automatic ignore_offset();
    int    errors_before;
    int    cycles;
    line_t data;
    line_t got;
    int    offsets [4] = '{0, 31, 8, 0};
    errors_before = error_count;
    offsets[3] = int'($random(seed)) & 31;
    random_line(data);
    write_line(line_address(21, 7), data, cycles);
    foreach (offsets[i])
    begin
        read_line(line_address(21, offsets[i]), got, cycles);
        compare_value($sformatf("line_o offset %0h", offsets[i]), data.flat, got.flat);
    end
    finish_test("offset bits ignored", errors_before);
endtask

task automatic overwrite_line();
    int    errors_before;
    int    cycles;
    line_t neighbour;
    line_t old_data;
    line_t new_data;
    line_t got;
    errors_before = error_count;
    random_line(neighbour);
    write_line(line_address(30, 0), neighbour, cycles);
    random_line(old_data);
    write_line(line_address(31, 0), old_data, cycles);
    random_line(new_data);
    write_line(line_address(31, 0), new_data, cycles);
    read_line(line_address(31, 0), got, cycles);
    compare_value("line_o rewritten line", new_data.flat, got.flat);
    read_line(line_address(30, 0), got, cycles);    // neighbour must be untouched
    compare_value("line_o neighbour line", neighbour.flat, got.flat);
    finish_test("overwrite", errors_before);
endtask

/* bench/tb_top.sv */
// testbench top: clock, reset, line memory instance, watchdog and the directed test sequence
`timescale 1ns/100ps

module tb_top;

    import line_pkg::*;

    // ========================================
    // timing and limits
    // ========================================
    localparam int CLK_PERIOD       = 40;
    localparam int RESET_CYCLES     = 3;
    localparam int NUM_TRANSFERS    = 26;                // all line transfers of all tests
    localparam int XFER_CYCLES      = MEM_LATENCY + 8;   // upper bound for one transfer
    localparam int WATCHDOG_CYCLES  = NUM_TRANSFERS * XFER_CYCLES * 2 + RESET_CYCLES + 4;

    // falling edges from driving a request to seeing resp_o
    localparam int READ_RESP_CYCLE  = MEM_LATENCY + 5;
    localparam int WRITE_RESP_CYCLE = MEM_LATENCY + 4;

    logic                 clk = 1'b0;
    logic                 reset_n;
    line_t                line_i;
    line_t                line_o;
    logic [ADDR_BITS-1:0] address_i;
    logic                 read_i;
    logic                 write_i;
    logic                 resp_o;

    integer               seed = 32'h3f07_2886;
    int                   error_count;
    int                   tests_passed;
    int                   tests_failed;

    line_t                shadow [MEM_LINES];    // expected memory contents

    line_memory_top dut0
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .line_i    (line_i),
        .address_i (address_i),
        .read_i    (read_i),
        .write_i   (write_i),
        .line_o    (line_o),
        .resp_o    (resp_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    `include "tb_tasks.svh"

    // ========================================
    // watchdog
    // ========================================
    initial
    begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    // ========================================
    // test sequence
    // ========================================
    initial
    begin : test_sequence
        reset_n      = 1'b0;
        read_i       = 1'b0;
        write_i      = 1'b0;
        address_i    = '0;
        line_i       = '0;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;

        verify_reset();
        readback_line();
        measure_latency();
        scatter_lines();
        ignore_offset();
        overwrite_line();

        $display("summary: %0d passed, %0d failed, %0d failing checks",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule : tb_top

/* tb.f */
+incdir+bench
common/line_pkg.sv
cacheline_adaptor/cacheline_adaptor.sv
burst_memory/burst_memory.sv
rtl/line_memory_top.sv
bench/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# build the line memory testbench with Verilator, run it, and judge the run by its log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_top \
    -Mdir obj_dir -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || echo "build or simulation ended with an error"

cat sim.log 2>/dev/null

grep -q "Test failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "Test completed successfully" sim.log || { echo "no pass line in the log"; exit 1; }

echo "simulation passed"
exit 0
